//--- capi_write_buffer.f
hw/capi_link_pkg.sv
hw/write_buffer_pkg.sv
hw/word_parity.sv
hw/tag_ram.sv
hw/write_data_stager.sv
hw/write_data_buffer.sv
hw/buffer_read_responder.sv
hw/capi_write_buffer.sv
sim/capi_write_buffer_properties.sv
sim/capi_write_buffer_tb.sv

//--- Bender.yml
package:
  name: capi_write_buffer

sources:
  # packages first, then RTL bottom up
  - hw/capi_link_pkg.sv
  - hw/write_buffer_pkg.sv
  - hw/word_parity.sv
  - hw/tag_ram.sv
  - hw/write_data_stager.sv
  - hw/write_data_buffer.sv
  - hw/buffer_read_responder.sv
  - hw/capi_write_buffer.sv
  - target: simulation
    files:
      - sim/capi_write_buffer_properties.sv
      - sim/capi_write_buffer_tb.sv

//--- sim/capi_write_buffer_tb.sv
/*
  directed testbench for the write-data buffer
  drives accelerator writes and host buffer reads on the falling edge and
  checks read_data, read_parity and data_write_error on every cycle
*/
`timescale 1ns/100ps
`default_nettype none

module capi_write_buffer_tb
  import capi_link_pkg::*;
  import write_buffer_pkg::*;
();

  localparam int double_words   = 8;
  localparam int half_line_bits = double_words * dword_bits;
  localparam int enable_timeout = 20;
  localparam logic [half_line_bits-1:0] idle_line = {double_words{idle_data_fill}};

  logic                         clock;
  logic                         rstn;
  logic                         enabled_in;
  logic                         write_half0_valid;
  logic                         write_half1_valid;
  logic [tag_bits-1:0]          write_tag;
  logic [half_line_bits-1:0]    write_data_0;
  logic [half_line_bits-1:0]    write_data_1;
  logic                         read_valid;
  logic [tag_bits-1:0]          read_tag;
  logic                         read_tag_parity;
  logic [read_address_bits-1:0] read_address;
  logic [half_line_bits-1:0]    read_data;
  logic [double_words-1:0]      read_parity;
  logic                         data_write_error;

  // line model, key is tag * 2 + half
  logic [half_line_bits-1:0] line_model [int];
  // expected port values, front entry is due at the next falling edge
  logic [half_line_bits-1:0] data_expect_q [$];
  logic                      error_expect_q [$];
  logic [tag_bits-1:0]       tag_list [$];

  logic [31:0] rng_state;
  // enabled_in as the stager will see it for the inputs of this cycle
  logic        enable_seen;

  int data_errors;
  int parity_errors;
  int flag_errors;
  int other_errors;
  int assertion_errors;
  int total_errors;

  capi_write_buffer #(
    .double_words(double_words)
  ) i_dut (
    .clock            (clock),
    .rstn             (rstn),
    .enabled_in       (enabled_in),
    .write_half0_valid(write_half0_valid),
    .write_half1_valid(write_half1_valid),
    .write_tag        (write_tag),
    .write_data_0     (write_data_0),
    .write_data_1     (write_data_1),
    .read_valid       (read_valid),
    .read_tag         (read_tag),
    .read_tag_parity  (read_tag_parity),
    .read_address     (read_address),
    .read_data        (read_data),
    .read_parity      (read_parity),
    .data_write_error (data_write_error)
  );

  bind buffer_read_responder capi_write_buffer_properties #(
    .double_words(double_words)
  ) i_properties (
    .clock           (clock),
    .rstn            (rstn),
    .req_valid       (req_valid),
    .req_tag         (req_tag),
    .req_tag_parity  (req_tag_parity),
    .read_data       (read_data),
    .data_write_error(data_write_error)
  );

  // 20 ns period
  always #10 clock = ~clock;

  ////////////////////////////////////////
  // stimulus and reference helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [half_line_bits-1:0] random_line();
    logic [half_line_bits-1:0] line;
    for (int i = 0; i < half_line_bits / 32; i++) begin
      line[i*32 +: 32] = next_random();
    end
    return line;
  endfunction

  // odd sense: ones in word plus parity bit come to an odd count
  function automatic logic [double_words-1:0] line_parity(input logic [half_line_bits-1:0] line);
    logic [double_words-1:0] p;
    for (int i = 0; i < double_words; i++) begin
      p[i] = (($countones(line[i*dword_bits +: dword_bits]) % 2) == 1) ^ odd_parity_sense;
    end
    return p;
  endfunction

  function automatic logic tag_parity(input logic [tag_bits-1:0] tag);
    return (($countones(tag) % 2) == 1) ^ odd_parity_sense;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input logic [half_line_bits-1:0] expected,
                            input logic [half_line_bits-1:0] actual);
    if (actual !== expected) begin
      data_errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_parity(input string name, input logic [double_words-1:0] expected,
                              input logic [double_words-1:0] actual);
    if (actual !== expected) begin
      parity_errors++;
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_error(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flag_errors++;
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // cycle tasks
  ////////////////////////////////////////

  // step to the next falling edge and check what is due there
  task automatic advance_cycle();
    logic [half_line_bits-1:0] exp_line;
    logic                      exp_error;
    enable_seen = enabled_in;
    @(negedge clock);
    exp_line  = data_expect_q.pop_front();
    exp_error = error_expect_q.pop_front();
    check_data("read_data", exp_line, read_data);
    check_parity("read_parity", line_parity(exp_line), read_parity);
    check_error("data_write_error", exp_error, data_write_error);
  endtask

  // data is due 3 edges on, the error flag 4 edges on
  task automatic commit_expectation();
    logic [half_line_bits-1:0] exp_line;
    logic                      exp_error;
    int                        key;
    exp_line  = idle_line;
    exp_error = 1'b0;
    if (read_valid && enable_seen) begin
      key = 2 * int'(read_tag) + int'(read_address != '0);
      if (line_model.exists(key)) begin
        exp_line = line_model[key];
      end else begin
        other_errors++;
        $display("read of tag %0h that was never written", read_tag);
      end
      exp_error = (read_tag_parity != tag_parity(read_tag));
    end
    data_expect_q.push_back(exp_line);
    error_expect_q.push_back(exp_error);
  endtask

  task automatic idle_cycle();
    advance_cycle();
    write_half0_valid = 1'b0;
    write_half1_valid = 1'b0;
    read_valid        = 1'b0;
    commit_expectation();
  endtask

  task automatic write_cycle(input logic [tag_bits-1:0] tag,
                             input logic [half_line_bits-1:0] d0,
                             input logic [half_line_bits-1:0] d1);
    advance_cycle();
    read_valid        = 1'b0;
    write_half0_valid = 1'b1;
    write_half1_valid = 1'b1;
    write_tag         = tag;
    write_data_0      = d0;
    write_data_1      = d1;
    // disabled writes never reach the memories
    if (enable_seen) begin
      line_model[2 * int'(tag)]     = d0;
      line_model[2 * int'(tag) + 1] = d1;
    end
    commit_expectation();
  endtask

  task automatic read_cycle(input logic [tag_bits-1:0] tag, input logic half,
                            input logic bad_parity);
    logic [31:0] r;
    r = next_random();
    advance_cycle();
    write_half0_valid = 1'b0;
    write_half1_valid = 1'b0;
    read_valid        = 1'b1;
    read_tag          = tag;
    read_tag_parity   = tag_parity(tag) ^ bad_parity;
    // any nonzero address selects half 1
    read_address      = half ? read_address_bits'(r % 63 + 1) : '0;
    commit_expectation();
  endtask

  task automatic wait_for_enable(input logic level);
    int cycles;
    bit reached;
    reached = 1'b0;
    for (cycles = 0; cycles < enable_timeout && !reached; cycles++) begin
      idle_cycle();
      if (i_dut.enabled === level) begin
        reached = 1'b1;
      end
    end
    if (!reached) begin
      other_errors++;
      $display("timeout waiting for the registered enable to reach %0b", level);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic idle_after_reset();
    check_data("read_data", idle_line, read_data);
    check_parity("read_parity", line_parity(idle_line), read_parity);
    check_error("data_write_error", 1'b0, data_write_error);
    repeat (4) idle_cycle();
  endtask

  task automatic write_and_read_back();
    logic [tag_bits-1:0] tag;
    repeat (6) begin
      tag = tag_bits'(next_random());
      tag_list.push_back(tag);
      write_cycle(tag, random_line(), random_line());
    end
    // memory write lands two edges after the port write
    idle_cycle();
    foreach (tag_list[i]) begin
      read_cycle(tag_list[i], 1'b0, 1'b0);
      read_cycle(tag_list[i], 1'b1, 1'b0);
      repeat (3) idle_cycle();
    end
  endtask

  task automatic back_to_back_reads();
    for (int i = 0; i < 8; i++) begin
      read_cycle(tag_list[i % tag_list.size()], (i % 2) == 1, 1'b0);
    end
    // one-cycle gap, idle fill expected between responses
    idle_cycle();
    read_cycle(tag_list[5], 1'b1, 1'b0);
    read_cycle(tag_list[2], 1'b0, 1'b0);
    idle_cycle();
    read_cycle(tag_list[3], 1'b1, 1'b0);
    repeat (4) idle_cycle();
  endtask

  task automatic bad_tag_parity();
    read_cycle(tag_list[0], 1'b0, 1'b1);
    repeat (5) idle_cycle();
    read_cycle(tag_list[1], 1'b1, 1'b0);
    repeat (5) idle_cycle();
    // two bad requests in a row, then a good one
    read_cycle(tag_list[2], 1'b0, 1'b1);
    read_cycle(tag_list[3], 1'b1, 1'b1);
    read_cycle(tag_list[4], 1'b0, 1'b0);
    repeat (5) idle_cycle();
  endtask

  task automatic enable_gating();
    enabled_in = 1'b0;
    wait_for_enable(1'b0);
    write_cycle(tag_list[0], random_line(), random_line());
    idle_cycle();
    read_cycle(tag_list[0], 1'b0, 1'b0);
    read_cycle(tag_list[0], 1'b1, 1'b1);
    repeat (5) idle_cycle();
    enabled_in = 1'b1;
    wait_for_enable(1'b1);
    // old contents still in place
    read_cycle(tag_list[0], 1'b0, 1'b0);
    read_cycle(tag_list[0], 1'b1, 1'b0);
    write_cycle(tag_list[1], random_line(), random_line());
    idle_cycle();
    read_cycle(tag_list[1], 1'b0, 1'b0);
    read_cycle(tag_list[1], 1'b1, 1'b0);
    repeat (5) idle_cycle();
  endtask

  initial begin
    clock             = 1'b0;
    rstn              = 1'b1;
    enabled_in        = 1'b0;
    write_half0_valid = 1'b0;
    write_half1_valid = 1'b0;
    write_tag         = '0;
    write_data_0      = '0;
    write_data_1      = '0;
    read_valid        = 1'b0;
    read_tag          = '0;
    read_tag_parity   = 1'b0;
    read_address      = '0;
    rng_state         = 32'hc8c1_65c7;
    enable_seen       = 1'b0;
    data_errors       = 0;
    parity_errors     = 0;
    flag_errors       = 0;
    other_errors      = 0;
    assertion_errors  = 0;

    // real falling reset edge ahead of the first rising clock edge
    #1 rstn = 1'b0;
    repeat (5) @(negedge clock);
    rstn = 1'b1;
    // pipeline still shows reset values for the first edges
    repeat (read_latency_cycles) data_expect_q.push_back(idle_line);
    repeat (read_latency_cycles + 1) error_expect_q.push_back(1'b0);

    idle_after_reset();
    enabled_in = 1'b1;
    wait_for_enable(1'b1);
    write_and_read_back();
    back_to_back_reads();
    bad_tag_parity();
    enable_gating();
    repeat (4) idle_cycle();

    assertion_errors = i_dut.responder_inst.i_properties.assert_failures;
    total_errors = data_errors + parity_errors + flag_errors + other_errors + assertion_errors;
    $display("errors: data %0d parity %0d error_flag %0d other %0d assertion %0d",
             data_errors, parity_errors, flag_errors, other_errors, assertion_errors);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : capi_write_buffer_tb

`default_nettype wire

//--- sim/capi_write_buffer_properties.sv
/*
  concurrent checks on the read responder, bound into every instance
  covers reset values, idle fill and the tag parity error pulse
*/
`timescale 1ns/100ps
`default_nettype none

module capi_write_buffer_properties
  import capi_link_pkg::*;
  import write_buffer_pkg::*;
#(
  parameter int double_words = 8
) (
  input wire logic                                 clock,
  input wire logic                                 rstn,
  input wire logic                                 req_valid,
  input wire logic [tag_bits-1:0]                  req_tag,
  input wire logic                                 req_tag_parity,
  input wire logic [double_words*dword_bits-1:0]   read_data,
  input wire logic                                 data_write_error
);

  localparam int half_line_bits = double_words * dword_bits;
  localparam logic [half_line_bits-1:0] idle_line = {double_words{idle_data_fill}};

  int unsigned assert_failures = 0;
  logic        bad_request;

  // request at the responder input whose tag parity is wrong
  assign bad_request = req_valid & (((^req_tag) ^ odd_parity_sense) != req_tag_parity);

  ////////////////////////////////////////
  // properties
  ////////////////////////////////////////

  // flag trails the bad request by three edges here
  a_error_pulse: assert property (@(posedge clock) disable iff (!rstn)
    data_write_error && $past(data_write_error) |-> $past(bad_request, 3) && $past(bad_request, 4))
  else begin
    assert_failures++;
    $error("data_write_error held high without two bad requests in a row");
  end

  a_reset_values: assert property (@(posedge clock)
    !rstn |-> (read_data == idle_line) && !data_write_error)
  else begin
    assert_failures++;
    $error("outputs not at idle fill or zero during reset");
  end

  // no request here is no request at the ports one cycle earlier
  a_idle_fill: assert property (@(posedge clock) disable iff (!rstn)
    !req_valid |-> ##2 (read_data == idle_line))
  else begin
    assert_failures++;
    $error("read_data not idle fill after a cycle without request");
  end

endmodule : capi_write_buffer_properties

`default_nettype wire

//--- hw/capi_write_buffer.sv
/*
  top level of the write-data buffer
  stager feeds the tagged storage, the responder answers host buffer reads
*/
`timescale 1ns/100ps
`default_nettype none

module capi_write_buffer
  import capi_link_pkg::*;
  import write_buffer_pkg::*;
#(
  parameter int double_words = 8
) (
  input  wire logic                                 clock,
  input  wire logic                                 rstn,
  input  wire logic                                 enabled_in,
  input  wire logic                                 write_half0_valid,
  input  wire logic                                 write_half1_valid,
  input  wire logic [tag_bits-1:0]                  write_tag,
  input  wire logic [double_words*dword_bits-1:0]   write_data_0,
  input  wire logic [double_words*dword_bits-1:0]   write_data_1,
  input  wire logic                                 read_valid,
  input  wire logic [tag_bits-1:0]                  read_tag,
  input  wire logic                                 read_tag_parity,
  input  wire logic [read_address_bits-1:0]         read_address,
  output logic      [double_words*dword_bits-1:0]   read_data,
  output logic      [double_words-1:0]              read_parity,
  output logic                                      data_write_error
);

  localparam int half_line_bits = double_words * dword_bits;

  // stager to buffer
  logic                      enabled;
  logic                      stage_half0_valid;
  logic                      stage_half1_valid;
  logic [tag_bits-1:0]       stage_tag;
  logic [half_line_bits-1:0] stage_data_0;
  logic [half_line_bits-1:0] stage_data_1;

  // buffer to responder
  logic                      req_valid;
  logic [tag_bits-1:0]       req_tag;
  logic                      req_tag_parity;
  logic                      req_select;
  logic [half_line_bits-1:0] half0_out;
  logic [half_line_bits-1:0] half1_out;

  write_data_stager #(
    .double_words(double_words)
  ) stager_inst (
    .clock            (clock),
    .rstn             (rstn),
    .enabled_in       (enabled_in),
    .write_half0_valid(write_half0_valid),
    .write_half1_valid(write_half1_valid),
    .write_tag        (write_tag),
    .write_data_0     (write_data_0),
    .write_data_1     (write_data_1),
    .enabled          (enabled),
    .stage_half0_valid(stage_half0_valid),
    .stage_half1_valid(stage_half1_valid),
    .stage_tag        (stage_tag),
    .stage_data_0     (stage_data_0),
    .stage_data_1     (stage_data_1)
  );

  write_data_buffer #(
    .double_words(double_words)
  ) buffer_inst (
    .clock            (clock),
    .rstn             (rstn),
    .enabled          (enabled),
    .stage_half0_valid(stage_half0_valid),
    .stage_half1_valid(stage_half1_valid),
    .stage_tag        (stage_tag),
    .stage_data_0     (stage_data_0),
    .stage_data_1     (stage_data_1),
    .read_valid       (read_valid),
    .read_tag         (read_tag),
    .read_tag_parity  (read_tag_parity),
    .read_address     (read_address),
    .req_valid        (req_valid),
    .req_tag          (req_tag),
    .req_tag_parity   (req_tag_parity),
    .req_select       (req_select),
    .half0_out        (half0_out),
    .half1_out        (half1_out)
  );

  buffer_read_responder #(
    .double_words(double_words)
  ) responder_inst (
    .clock           (clock),
    .rstn            (rstn),
    .req_valid       (req_valid),
    .req_tag         (req_tag),
    .req_tag_parity  (req_tag_parity),
    .req_select      (req_select),
    .half0_out       (half0_out),
    .half1_out       (half1_out),
    .read_data       (read_data),
    .read_parity     (read_parity),
    .data_write_error(data_write_error)
  );

endmodule : capi_write_buffer

`default_nettype wire

//--- hw/buffer_read_responder.sv
/*
  read side of the buffer: picks the requested half line or idle fill,
  adds odd parity per double word and drives the host read ports
  a bad tag parity is flagged one cycle after the data
*/
`timescale 1ns/100ps
`default_nettype none

module buffer_read_responder
  import capi_link_pkg::*;
  import write_buffer_pkg::*;
#(
  parameter int double_words = 8
) (
  input  wire logic                                 clock,
  input  wire logic                                 rstn,
  input  wire logic                                 req_valid,
  input  wire logic [tag_bits-1:0]                  req_tag,
  input  wire logic                                 req_tag_parity,
  input  wire logic                                 req_select,
  input  wire logic [double_words*dword_bits-1:0]   half0_out,
  input  wire logic [double_words*dword_bits-1:0]   half1_out,
  output logic      [double_words*dword_bits-1:0]   read_data,
  output logic      [double_words-1:0]              read_parity,
  output logic                                      data_write_error
);

  localparam int half_line_bits = double_words * dword_bits;

  // request register, select register, output register
  localparam int pipe_stages = 3;

  localparam logic [half_line_bits-1:0] idle_line = {double_words{idle_data_fill}};
  localparam logic idle_dword_parity = (^idle_data_fill) ^ odd_parity_sense;

  logic [half_line_bits-1:0] selected_data;
  logic [double_words-1:0]   selected_parity;
  logic                      tag_parity_calc;
  logic                      tag_mismatch;
  logic                      tag_mismatch_d;

  if (pipe_stages != read_latency_cycles) begin : g_latency_check
    $error("read pipeline depth does not match read_latency_cycles");
  end

  ////////////////////////////////////////
  // half select, R+2
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      selected_data <= idle_line;
    end else if (req_valid) begin
      selected_data <= req_select ? half1_out : half0_out;
    end else begin
      selected_data <= idle_line;
    end
  end

  // parity over the selected line, settles before R+3
  word_parity #(
    .groups    (double_words),
    .group_bits(dword_bits)
  ) data_parity_inst (
    .data  (selected_data),
    .odd   (odd_parity_sense),
    .parity(selected_parity)
  );

  ////////////////////////////////////////
  // output ports, R+3
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      read_data   <= idle_line;
      read_parity <= {double_words{idle_dword_parity}};
    end else begin
      read_data   <= selected_data;
      read_parity <= selected_parity;
    end
  end

  ////////////////////////////////////////
  // tag parity check
  ////////////////////////////////////////

  word_parity #(
    .groups    (1),
    .group_bits(tag_bits)
  ) tag_parity_inst (
    .data  (req_tag),
    .odd   (odd_parity_sense),
    .parity(tag_parity_calc)
  );

  // mismatch at R+2, delayed so the flag trails the data by one cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_mismatch     <= 1'b0;
      tag_mismatch_d   <= 1'b0;
      data_write_error <= 1'b0;
    end else begin
      tag_mismatch     <= req_valid & (tag_parity_calc ^ req_tag_parity);
      tag_mismatch_d   <= tag_mismatch;
      data_write_error <= tag_mismatch_d;
    end
  end

endmodule : buffer_read_responder

`default_nettype wire

//--- hw/write_data_buffer.sv
/*
  tagged storage for both half line lanes
  writes come from the stager, reads are addressed straight from the host
  request and the request is registered in step with the memory outputs
*/
`timescale 1ns/100ps
`default_nettype none

module write_data_buffer
  import capi_link_pkg::*;
  import write_buffer_pkg::*;
#(
  parameter int double_words = 8
) (
  input  wire logic                                 clock,
  input  wire logic                                 rstn,
  input  wire logic                                 enabled,
  input  wire logic                                 stage_half0_valid,
  input  wire logic                                 stage_half1_valid,
  input  wire logic [tag_bits-1:0]                  stage_tag,
  input  wire logic [double_words*dword_bits-1:0]   stage_data_0,
  input  wire logic [double_words*dword_bits-1:0]   stage_data_1,
  input  wire logic                                 read_valid,
  input  wire logic [tag_bits-1:0]                  read_tag,
  input  wire logic                                 read_tag_parity,
  input  wire logic [read_address_bits-1:0]         read_address,
  output logic                                      req_valid,
  output logic      [tag_bits-1:0]                  req_tag,
  output logic                                      req_tag_parity,
  output logic                                      req_select,
  output logic      [double_words*dword_bits-1:0]   half0_out,
  output logic      [double_words*dword_bits-1:0]   half1_out
);

  localparam int half_line_bits = double_words * dword_bits;

  ////////////////////////////////////////
  // half line memories
  ////////////////////////////////////////

  // lane 0, lower half of the cache line
  tag_ram #(
    .width(half_line_bits),
    .depth(tag_depth)
  ) half0_ram_inst (
    .clock        (clock),
    .write_enable (stage_half0_valid),
    .write_address(stage_tag),
    .write_data   (stage_data_0),
    .read_address (read_tag),
    .read_data    (half0_out)
  );

  // lane 1, upper half
  tag_ram #(
    .width(half_line_bits),
    .depth(tag_depth)
  ) half1_ram_inst (
    .clock        (clock),
    .write_enable (stage_half1_valid),
    .write_address(stage_tag),
    .write_data   (stage_data_1),
    .read_address (read_tag),
    .read_data    (half1_out)
  );

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////

  // lines up with the registered memory read
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      req_valid      <= 1'b0;
      req_tag        <= '0;
      req_tag_parity <= 1'b0;
      req_select     <= 1'b0;
    end else if (read_valid && enabled) begin
      req_valid      <= 1'b1;
      req_tag        <= read_tag;
      req_tag_parity <= read_tag_parity;
      // any nonzero address picks half 1
      req_select     <= |read_address;
    end else begin
      req_valid      <= 1'b0;
      req_tag        <= '0;
      req_tag_parity <= 1'b0;
      req_select     <= 1'b0;
    end
  end

endmodule : write_data_buffer

`default_nettype wire

//--- hw/write_data_stager.sv
/*
  write side of the buffer: registers the link enable and latches the
  accelerator half line writes with their tag, one edge before the memory write
*/
`timescale 1ns/100ps
`default_nettype none

module write_data_stager
  import capi_link_pkg::*;
  import write_buffer_pkg::*;
#(
  parameter int double_words = 8
) (
  input  wire logic                                 clock,
  input  wire logic                                 rstn,
  input  wire logic                                 enabled_in,
  input  wire logic                                 write_half0_valid,
  input  wire logic                                 write_half1_valid,
  input  wire logic [tag_bits-1:0]                  write_tag,
  input  wire logic [double_words*dword_bits-1:0]   write_data_0,
  input  wire logic [double_words*dword_bits-1:0]   write_data_1,
  output logic                                      enabled,
  output logic                                      stage_half0_valid,
  output logic                                      stage_half1_valid,
  output logic      [tag_bits-1:0]                  stage_tag,
  output logic      [double_words*dword_bits-1:0]   stage_data_0,
  output logic      [double_words*dword_bits-1:0]   stage_data_1
);

  ////////////////////////////////////////
  // enable and write strobes
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled           <= 1'b0;
      stage_half0_valid <= 1'b0;
      stage_half1_valid <= 1'b0;
      stage_tag         <= '0;
    end else begin
      enabled           <= enabled_in;
      // writes only count once the registered enable is up
      stage_half0_valid <= write_half0_valid & enabled;
      stage_half1_valid <= write_half1_valid & enabled;
      if (enabled) begin
        stage_tag <= write_tag;
      end
    end
  end

  ////////////////////////////////////////
  // payload, qualified by the strobes
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    stage_data_0 <= write_data_0;
    stage_data_1 <= write_data_1;
  end

endmodule : write_data_stager

`default_nettype wire

//--- hw/tag_ram.sv
/*
  tag addressed memory, one synchronous write port and one registered read port
  read during a write to the same entry returns the old contents
*/
`timescale 1ns/100ps
`default_nettype none

module tag_ram #(
  parameter int width = 512,
  parameter int depth = 256
) (
  input  wire logic                     clock,
  input  wire logic                     write_enable,
  input  wire logic [$clog2(depth)-1:0] write_address,
  input  wire logic [width-1:0]         write_data,
  input  wire logic [$clog2(depth)-1:0] read_address,
  output logic      [width-1:0]         read_data
);

  logic [width-1:0] mem [depth];

  // write side
  always_ff @(posedge clock) begin
    if (write_enable) begin
      mem[write_address] <= write_data;
    end
  end

  // read side, one edge of latency
  always_ff @(posedge clock) begin
    read_data <= mem[read_address];
  end

endmodule : tag_ram

`default_nettype wire

//--- hw/word_parity.sv
/*
  parity per group of a bus, one result bit per group
  odd = 1 gives odd parity, odd = 0 gives even parity
*/
`timescale 1ns/100ps
`default_nettype none

module word_parity
  import write_buffer_pkg::*;
#(
  parameter int groups     = 8,
  parameter int group_bits = dword_bits
) (
  input  wire logic [groups*group_bits-1:0] data,
  input  wire logic                         odd,
  output logic      [groups-1:0]            parity
);

  // xor reduce each slice, flip for odd sense
  for (genvar g = 0; g < groups; g++) begin : g_group
    assign parity[g] = (^data[g*group_bits +: group_bits]) ^ odd;
  end

endmodule : word_parity

`default_nettype wire

//--- hw/write_buffer_pkg.sv
/*
  geometry of the write-data buffer
  one parity group per double word, plus the fill shown when no read is in flight
*/
`default_nettype none

package write_buffer_pkg;

  // one parity group
  localparam int dword_bits = 64;

  // idle fill for one double word, replicated across a half line
  localparam logic [dword_bits-1:0] idle_data_fill = '1;

endpackage : write_buffer_pkg

`default_nettype wire

//--- hw/capi_link_pkg.sv
/*
  host link constants shared by the write-data buffer and its testbench
  tag geometry, parity sense on the link and the fixed buffer read latency
*/
`default_nettype none

package capi_link_pkg;

  // command tag width and the number of tagged entries
  localparam int tag_bits  = 8;
  localparam int tag_depth = 2 ** tag_bits;

  // buffer read address field (ha_brad), zero means half 0
  localparam int read_address_bits = 6;

  // odd parity on tags and data
  localparam logic odd_parity_sense = 1'b1;

  // edges from a sampled read request to valid data on the ports
  // fixed by the pipeline, never a port
  localparam int read_latency_cycles = 3;

endpackage : capi_link_pkg

`default_nettype wire
